/* verilog/matrix_pkg.sv */
/* Shared sizes, element types, operation codes and seed for the matrix element engine.
   Every module of the engine refers to these definitions. */
package matrix_pkg;

    // Matrix dimension, rows equal columns
    parameter int mat_dim = 4;

    typedef logic [7:0]  elem_t;  // Operand element
    typedef logic [15:0] res_t;   // Result element

    // Element-wise operation codes
    typedef enum logic [2:0] {
        op_add  = 3'd0,  // a + b
        op_sub  = 3'd1,  // a - b, wraps
        op_mul  = 3'd2,  // a * b
        op_mac  = 3'd3,  // a * b + c
        op_xor  = 3'd4,  // {d, a ^ b ^ e}
        op_max  = 3'd5,  // Unsigned max of a and b
        op_wsum = 3'd6,  // a * c + b * d
        op_sum5 = 3'd7   // a + b + c + d + e
    } op_t;

    // One request to the element operation unit, 43 bits
    typedef struct packed {
        elem_t a;
        elem_t b;
        elem_t c;
        elem_t d;
        elem_t e;
        op_t   op;
    } elem_req_t;

    // Pattern lanes taken from the shift register
    typedef struct packed {
        elem_t c;  // Bits 31:24
        elem_t d;  // Bits 23:16
        elem_t e;  // Bits 15:8
    } pat_bytes_t;

    // Whole matrices, indexed [row][col]
    typedef elem_t [mat_dim-1:0][mat_dim-1:0] mat_in_t;   // 128 bits
    typedef res_t  [mat_dim-1:0][mat_dim-1:0] mat_out_t;  // 256 bits

    // Reset value of the pattern register
    parameter logic [95:0] pat_seed = 96'h123456789ABCDEF012345678;

endpackage

/* verilog/pattern_lfsr.sv */
/* Pattern register for the c, d and e operands.
   Loads the seed on reset and advances one position per step strobe. */
`timescale 1ns/1ps

module pattern_lfsr #(
    parameter logic [95:0] PATTERN_SEED = matrix_pkg::pat_seed
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   step,
    output matrix_pkg::pat_bytes_t pat
);

    logic [95:0] lfsr_q;
    logic        fb;

    // Taps at the top bit of each 32-bit word
    assign fb = lfsr_q[95] ^ lfsr_q[63] ^ lfsr_q[31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q <= PATTERN_SEED;
        end else if (step) begin
            lfsr_q <= {lfsr_q[94:0], fb};  // Shift left, feed in at bit 0
        end
    end

    // Three byte lanes from the low word
    assign pat = '{
        c: lfsr_q[31:24],
        d: lfsr_q[23:16],
        e: lfsr_q[15:8]
    };

endmodule

/* verilog/elem_op_unit.sv */
/* Combinational element operation unit.
   Maps one element request to a 16-bit result by the published rule of its code. */
`timescale 1ns/1ps

module elem_op_unit (
    input  matrix_pkg::elem_req_t req,
    output matrix_pkg::res_t      y
);

    import matrix_pkg::*;

    // Operands widened to result width, all math wraps at 16 bits
    res_t a_w;
    res_t b_w;
    res_t c_w;
    res_t d_w;
    res_t e_w;

    assign a_w = {8'h00, req.a};
    assign b_w = {8'h00, req.b};
    assign c_w = {8'h00, req.c};
    assign d_w = {8'h00, req.d};
    assign e_w = {8'h00, req.e};

    always_comb begin
        case (req.op)
            op_add: begin
                y = a_w + b_w;
            end
            op_sub: begin
                y = a_w - b_w;  // Negative results wrap
            end
            op_mul: begin
                y = a_w * b_w;
            end
            op_mac: begin
                y = a_w * b_w + c_w;
            end
            op_xor: begin
                // Pattern byte d on top, mixed operands below
                y = {req.d, req.a ^ req.b ^ req.e};
            end
            op_max: begin
                y = (req.a > req.b) ? a_w : b_w;
            end
            op_wsum: begin
                y = a_w * c_w + b_w * d_w;
            end
            op_sum5: begin
                y = a_w + b_w + c_w + d_w + e_w;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

/* verilog/matrix_sequencer.sv */
/* Job FSM of the matrix engine. Walks positions in row-major order, builds requests,
   writes each result to the bank and steps the pattern register once per element. */
`timescale 1ns/1ps

module matrix_sequencer #(
    parameter int MATRIX_SIZE = matrix_pkg::mat_dim
) (
    input  logic                           clk,
    input  logic                           rst,
    input  matrix_pkg::mat_in_t            mat_a,
    input  matrix_pkg::mat_in_t            mat_b,
    input  matrix_pkg::op_t                op,
    input  logic                           start,
    input  matrix_pkg::pat_bytes_t         pat,
    input  matrix_pkg::res_t               y,
    output matrix_pkg::elem_req_t          req,
    output logic                           wr_en,
    output logic [$clog2(MATRIX_SIZE)-1:0] wr_row,
    output logic [$clog2(MATRIX_SIZE)-1:0] wr_col,
    output matrix_pkg::res_t               wr_data,
    output logic                           step,
    output logic                           ready
);

    import matrix_pkg::*;

    localparam int idx_w = $clog2(MATRIX_SIZE);
    localparam logic [idx_w-1:0] last_idx = idx_w'(MATRIX_SIZE - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_next,
        st_complete
    } state_t;

    state_t           state;
    logic [idx_w-1:0] row;
    logic [idx_w-1:0] col;
    op_t              op_q;  // Code of the running job

    // Request for the current position
    assign req = '{
        a:  mat_a[row][col],
        b:  mat_b[row][col],
        c:  pat.c,
        d:  pat.d,
        e:  pat.e,
        op: op_q
    };

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            row   <= '0;
            col   <= '0;
            op_q  <= op_add;
            wr_en <= 1'b0;
            step  <= 1'b0;
            ready <= 1'b0;
        end else begin
            wr_en <= 1'b0;  // Strobes last one cycle
            step  <= 1'b0;
            ready <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin  // Start only seen here
                        row   <= '0;
                        col   <= '0;
                        op_q  <= op;
                        state <= st_compute;
                    end
                end
                st_compute: begin
                    wr_en <= 1'b1;
                    step  <= 1'b1;  // Pattern advances with the write
                    state <= st_next;
                end
                st_next: begin
                    if (col != last_idx) begin
                        col   <= col + 1'b1;
                        state <= st_compute;
                    end else if (row != last_idx) begin
                        col   <= '0;
                        row   <= row + 1'b1;
                        state <= st_compute;
                    end else begin
                        state <= st_complete;  // Last write lands this edge
                    end
                end
                st_complete: begin
                    ready <= 1'b1;
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Result and position captured together with wr_en
    always_ff @(posedge clk) begin
        if (state == st_compute) begin
            wr_row  <= row;
            wr_col  <= col;
            wr_data <= y;
        end
    end

endmodule

/* verilog/result_bank.sv */
/* Registered bank of result elements for the matrix engine.
   Written one element per wr_en and read as a whole matrix. */
`timescale 1ns/1ps

module result_bank #(
    parameter int MATRIX_SIZE = matrix_pkg::mat_dim
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_en,
    input  logic [$clog2(MATRIX_SIZE)-1:0] wr_row,
    input  logic [$clog2(MATRIX_SIZE)-1:0] wr_col,
    input  matrix_pkg::res_t               wr_data,
    output matrix_pkg::mat_out_t           result
);

    localparam int idx_w = $clog2(MATRIX_SIZE);

    // One write decode per element
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;  // Bank reads zero after reset
        end else if (wr_en) begin
            for (int r = 0; r < MATRIX_SIZE; r++) begin
                for (int c = 0; c < MATRIX_SIZE; c++) begin
                    if (wr_row == idx_w'(r) && wr_col == idx_w'(c)) begin
                        result[r][c] <= wr_data;
                    end
                end
            end
        end
    end

endmodule

/* verilog/matrix_host.sv */
/* Top level of the matrix element engine.
   Host loads two matrices and an op code, pulses start and waits for the ready strobe. */
`timescale 1ns/1ps

module matrix_host #(
    parameter int          MATRIX_SIZE  = matrix_pkg::mat_dim,
    parameter logic [95:0] PATTERN_SEED = matrix_pkg::pat_seed
) (
    input  logic                 clk,
    input  logic                 rst,
    input  matrix_pkg::mat_in_t  mat_a,
    input  matrix_pkg::mat_in_t  mat_b,
    input  matrix_pkg::op_t      op,
    input  logic                 start,
    output matrix_pkg::mat_out_t result,
    output logic                 ready
);

    import matrix_pkg::*;

    elem_req_t                      req;
    res_t                           y;
    pat_bytes_t                     pat;
    logic                           step;
    logic                           wr_en;
    logic [$clog2(MATRIX_SIZE)-1:0] wr_row;
    logic [$clog2(MATRIX_SIZE)-1:0] wr_col;
    res_t                           wr_data;

    matrix_sequencer #(
        .MATRIX_SIZE (MATRIX_SIZE)
    ) seq_i (
        .clk     (clk),
        .rst     (rst),
        .mat_a   (mat_a),
        .mat_b   (mat_b),
        .op      (op),
        .start   (start),
        .pat     (pat),
        .y       (y),
        .req     (req),
        .wr_en   (wr_en),
        .wr_row  (wr_row),
        .wr_col  (wr_col),
        .wr_data (wr_data),
        .step    (step),
        .ready   (ready)
    );

    pattern_lfsr #(
        .PATTERN_SEED (PATTERN_SEED)
    ) lfsr_i (
        .clk  (clk),
        .rst  (rst),
        .step (step),
        .pat  (pat)
    );

    // Zero latency, result sampled by the sequencer
    elem_op_unit op_i (
        .req (req),
        .y   (y)
    );

    result_bank #(
        .MATRIX_SIZE (MATRIX_SIZE)
    ) bank_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_row  (wr_row),
        .wr_col  (wr_col),
        .wr_data (wr_data),
        .result  (result)
    );

endmodule

/* verification/matrix_host_tb.sv */
/* Directed testbench for the matrix element engine. Models the pattern register and the
   operation rules, runs jobs through the DUT and checks every result element. */
`timescale 1ns/1ps

module matrix_host_tb;

    import matrix_pkg::*;

    localparam int job_cycles    = 33;   // Start edge to ready edge
    localparam int ready_timeout = 100;

    logic     clk;
    logic     rst;
    mat_in_t  mat_a;
    mat_in_t  mat_b;
    op_t      op;
    logic     start;
    mat_out_t result;
    logic     ready;

    logic [95:0] lfsr_model;  // Reference copy of the pattern register
    integer      seed = 32'h6922_3777;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    matrix_host dut_i (
        .clk    (clk),
        .rst    (rst),
        .mat_a  (mat_a),
        .mat_b  (mat_b),
        .op     (op),
        .start  (start),
        .result (result),
        .ready  (ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Element rule per op code, everything wraps at 16 bits
    function automatic res_t expected_element(input op_t code, input elem_t a, input elem_t b,
                                              input elem_t c, input elem_t d, input elem_t e);
        logic [31:0] s;
        case (code)
            op_add:  s = int'(a) + int'(b);
            op_sub:  s = int'(a) - int'(b);
            op_mul:  s = int'(a) * int'(b);
            op_mac:  s = int'(a) * int'(b) + int'(c);
            op_xor:  s = {16'h0000, d, a ^ b ^ e};
            op_max:  s = (a >= b) ? int'(a) : int'(b);
            op_wsum: s = int'(a) * int'(c) + int'(b) * int'(d);
            default: s = int'(a) + int'(b) + int'(c) + int'(d) + int'(e);
        endcase
        return s[15:0];
    endfunction

    // One shift left, feedback from the top bit of each word
    task automatic step_pattern();
        lfsr_model = {lfsr_model[94:0], lfsr_model[95] ^ lfsr_model[63] ^ lfsr_model[31]};
    endtask

    // Walks the job in row-major order, one pattern step per element
    task automatic predict_job(input op_t code, output mat_out_t exp);
        for (int r = 0; r < mat_dim; r++) begin
            for (int c = 0; c < mat_dim; c++) begin
                exp[r][c] = expected_element(code, mat_a[r][c], mat_b[r][c],
                    lfsr_model[31:24], lfsr_model[23:16], lfsr_model[15:8]);
                step_pattern();
            end
        end
    endtask

    task automatic randomize_operands();
        for (int r = 0; r < mat_dim; r++) begin
            for (int c = 0; c < mat_dim; c++) begin
                mat_a[r][c] = 8'($random(seed));
                mat_b[r][c] = 8'($random(seed));
            end
        end
    endtask

    task automatic fill_operands(input elem_t a_val, input elem_t b_val);
        for (int r = 0; r < mat_dim; r++) begin
            for (int c = 0; c < mat_dim; c++) begin
                mat_a[r][c] = a_val;
                mat_b[r][c] = b_val;
            end
        end
    endtask

    // Leaves the caller 1 ns after the edge that samples start
    task automatic pulse_start(input op_t code);
        @(posedge clk);
        #1;
        op    = code;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_ready(output int cycles, output bit ok);
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < ready_timeout) begin
            @(posedge clk);
            cycles++;
            #1;
            ok = ready;
        end
        if (!ok) begin
            $display("Timeout: ready did not arrive within %0d cycles", ready_timeout);
            errors++;
        end
    endtask

    task automatic check_ready_low();
        assert (ready === 1'b0) else begin
            $display("Mismatch at time %0t: ready got %b expected 0", $time, ready);
            errors++;
        end
    endtask

    task automatic check_latency(input int cycles);
        assert (cycles == job_cycles) else begin
            $display("Mismatch at time %0t: ready latency got %0d expected %0d",
                     $time, cycles, job_cycles);
            errors++;
        end
    endtask

    task automatic compare_result(input mat_out_t exp);
        for (int r = 0; r < mat_dim; r++) begin
            for (int c = 0; c < mat_dim; c++) begin
                assert (result[r][c] === exp[r][c]) else begin
                    $display("Mismatch at time %0t: result[%0d][%0d] got %h expected %h",
                             $time, r, c, result[r][c], exp[r][c]);
                    errors++;
                end
            end
        end
    endtask

    task automatic run_job(input op_t code);
        mat_out_t exp;
        int       cycles;
        bit       ok;
        predict_job(code, exp);
        pulse_start(code);
        wait_ready(cycles, ok);
        if (ok) begin
            check_latency(cycles);
            compare_result(exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        int found;
        found = errors - errors_before;
        tests_run++;
        if (found == 0) begin
            $display("%s: done, no errors", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, found);
        end
    endtask

    task automatic test_reset_state();
        int start_errors;
        start_errors = errors;
        check_ready_low();
        compare_result('0);
        finish_test("reset_state", start_errors);
    endtask

    task automatic test_independent_ops();
        int  start_errors;
        op_t codes[4];
        start_errors = errors;
        codes = '{op_add, op_sub, op_mul, op_max};
        foreach (codes[i]) begin
            randomize_operands();
            run_job(codes[i]);
        end
        finish_test("independent_ops", start_errors);
    endtask

    // Back-to-back jobs, pattern carries over
    task automatic test_pattern_ops();
        int  start_errors;
        op_t codes[4];
        start_errors = errors;
        codes = '{op_mac, op_xor, op_wsum, op_sum5};
        foreach (codes[i]) begin
            randomize_operands();
            run_job(codes[i]);
        end
        finish_test("pattern_ops", start_errors);
    endtask

    task automatic test_job_timing();
        int start_errors;
        start_errors = errors;
        randomize_operands();
        run_job(op_mac);
        @(posedge clk);
        #1;
        check_ready_low();  // Ready is a single-cycle strobe
        finish_test("job_timing", start_errors);
    endtask

    task automatic test_start_busy();
        int       start_errors;
        mat_out_t exp;
        int       cycles;
        bit       ok;
        start_errors = errors;
        randomize_operands();
        predict_job(op_mul, exp);
        pulse_start(op_mul);
        repeat (9) @(posedge clk);
        #1;
        op    = op_add;  // Different code, must be ignored
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_ready(cycles, ok);
        if (ok) begin
            check_latency(cycles + 10);
            compare_result(exp);
            for (int i = 0; i < 40; i++) begin
                @(posedge clk);
                #1;
                check_ready_low();
            end
        end
        finish_test("start_busy", start_errors);
    endtask

    task automatic test_edge_values();
        int start_errors;
        start_errors = errors;
        fill_operands(8'h00, 8'hFF);
        run_job(op_sub);  // 0 - 255 wraps to ff01
        fill_operands(8'hFF, 8'hFF);
        run_job(op_mul);
        run_job(op_sum5);
        fill_operands(8'h00, 8'h00);
        run_job(op_sum5);
        finish_test("edge_values", start_errors);
    endtask

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        op         = op_add;
        mat_a      = '0;
        mat_b      = '0;
        lfsr_model = 96'h123456789ABCDEF012345678;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_state();
        test_independent_ops();
        test_pattern_ops();
        test_job_timing();
        test_start_busy();
        test_edge_values();

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/matrix_pkg.sv
verilog/pattern_lfsr.sv
verilog/elem_op_unit.sv
verilog/matrix_sequencer.sv
verilog/result_bank.sv
verilog/matrix_host.sv
verification/matrix_host_tb.sv
